// ==== flist.f ====
+incdir+source
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_control.sv
source/cpu_core.sv
sim/tb_cpu_core.sv

// ==== Makefile ====
# Verilator build and run of the cpu core testbench

build:
	verilator --binary --timing --timescale 1ns/1ns -f flist.f \
		--top-module tb_cpu_core --Mdir obj_dir -o tb_cpu_core

run: build
	./obj_dir/tb_cpu_core | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: build run clean

// ==== sim/tb_cpu_core.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module tb_cpu_core
  import cpu_pkg::*;
();

  localparam int MEM_WORDS    = 256;
  localparam int HALT_TIMEOUT = 2000;

  logic  clk_i;
  logic  rst_i;
  logic  ack_i;
  word_t dat_i;
  logic  cyc_o;
  logic  we_o;
  addr_t adr_o;
  word_t dat_o;
  logic  halt_o;

  word_t       mem [MEM_WORDS];     // what the DUT sees
  word_t       ref_mem [MEM_WORDS]; // model image after the run
  addr_t       exp_addr_q [$];
  word_t       exp_data_q [$];
  logic [31:0] lfsr;
  logic        mem_busy;
  logic [1:0]  wait_left;
  int          asm_pc;
  int          error_count;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;

  cpu_core u_dut (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .ack_i  (ack_i),
    .dat_i  (dat_i),
    .cyc_o  (cyc_o),
    .we_o   (we_o),
    .adr_o  (adr_o),
    .dat_o  (dat_o),
    .halt_o (halt_o)
  );

  always #20 clk_i = ~clk_i;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic word_t enc_ldi(input int ra, input int imm);
    return {`OP_LDI, ra[3:0], 4'h0, imm[15:0]};
  endfunction

  function automatic word_t enc_alu(input int ra, input int rb, input int rc, input int f);
    return {`OP_ALU, ra[3:0], rb[3:0], rc[3:0], 9'd0, f[2:0]};
  endfunction

  function automatic word_t enc_mem(input opcode_t op, input int ra, input int rb, input int imm);
    return {op, ra[3:0], rb[3:0], imm[15:0]};
  endfunction

  function automatic word_t enc_br(input opcode_t op, input int imm);
    return {op, 8'h00, imm[15:0]};
  endfunction

  task automatic emit(input word_t ins);
    mem[asm_pc] = ins;
    asm_pc++;
  endtask

  task automatic new_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hc0de_0000 + i; // differs per word
    end
    asm_pc = 0;
  endtask

  function automatic word_t ref_alu(input logic [2:0] f, input word_t x, input word_t y);
    case (f)
      ALU_ADD: return x + y;
      ALU_SUB: return x - y;
      ALU_AND: return x & y;
      ALU_OR:  return x | y;
      ALU_XOR: return x ^ y;
      ALU_SHL: return x << y[4:0];
      ALU_SHR: return x >> y[4:0];
      default: return 32'h0;
    endcase
  endfunction

  // instruction-level model; fills the expected stores and ref_mem
  function automatic void ref_run();
    word_t r [`CPU_NUM_REGS];
    addr_t pc;
    addr_t ea;
    word_t ins;
    word_t imm;
    word_t res;
    logic  zero;
    logic  done;
    int    steps;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = mem[i];
    end
    for (int i = 0; i < `CPU_NUM_REGS; i++) begin
      r[i] = 32'h0;
    end
    exp_addr_q.delete();
    exp_data_q.delete();
    pc    = `CPU_RESET_PC;
    zero  = 1'b0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < HALT_TIMEOUT) begin
      ins = ref_mem[pc[9:2]];
      pc  = pc + 32'd4;
      imm = {{16{ins[`IR_IMM_HI]}}, ins[`IR_IMM_HI:`IR_IMM_LO]};
      ea  = r[ins[`IR_RB_HI:`IR_RB_LO]] + imm;
      case (ins[`IR_OP_HI:`IR_OP_LO])
        `OP_LDI: r[ins[`IR_RA_HI:`IR_RA_LO]] = imm;
        `OP_ALU: begin
          res  = ref_alu(ins[`IR_FUNC_HI:`IR_FUNC_LO], r[ins[`IR_RB_HI:`IR_RB_LO]],
                         r[ins[`IR_RC_HI:`IR_RC_LO]]);
          zero = (res == 32'h0);
          r[ins[`IR_RA_HI:`IR_RA_LO]] = res;
        end
        `OP_LD: r[ins[`IR_RA_HI:`IR_RA_LO]] = ref_mem[ea[9:2]];
        `OP_ST: begin
          ref_mem[ea[9:2]] = r[ins[`IR_RA_HI:`IR_RA_LO]];
          exp_addr_q.push_back(ea);
          exp_data_q.push_back(r[ins[`IR_RA_HI:`IR_RA_LO]]);
        end
        `OP_BEQ: if (zero) pc = pc + (imm << 2);
        `OP_BNE: if (!zero) pc = pc + (imm << 2);
        default: done = 1'b1; // halt, or unknown opcode
      endcase
      steps++;
    end
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  // memory with 0 to 3 wait states per transfer
  initial begin
    ack_i     = 1'b0;
    dat_i     = 32'h0;
    mem_busy  = 1'b0;
    wait_left = 2'd0;
    lfsr      = 32'he804_6fa2;
    forever begin
      @(posedge clk_i);
      #5;
      if (ack_i) begin // transfer ended on this edge
        ack_i    = 1'b0;
        dat_i    = 32'h0;
        mem_busy = 1'b0;
      end
      if (!cyc_o) begin
        mem_busy = 1'b0;
      end else if (!mem_busy) begin
        mem_busy     = 1'b1;
        lfsr         = lfsr_next(lfsr);
        wait_left[0] = lfsr[0];
        lfsr         = lfsr_next(lfsr);
        wait_left[1] = lfsr[0];
      end
      if (mem_busy) begin
        if (wait_left == 2'd0) begin
          ack_i = 1'b1;
          if (we_o) begin
            mem[adr_o[9:2]] = dat_o;
          end else begin
            dat_i = mem[adr_o[9:2]];
          end
        end else begin
          wait_left = wait_left - 2'd1;
        end
      end
    end
  end

  // each completed write against the next expected store
  initial begin
    forever begin
      @(negedge clk_i);
      if (cyc_o && ack_i && !we_o) begin
        check_word("dat_o", dat_o, 32'h0);
      end
      if (cyc_o && we_o && ack_i) begin
        if (exp_addr_q.size() == 0) begin
          $display("store of %h to %h at %0t ns was not expected", dat_o, adr_o, $time);
          error_count++;
        end else begin
          check_addr("adr_o", adr_o, exp_addr_q.pop_front());
          check_word("dat_o", dat_o, exp_data_q.pop_front());
        end
      end
    end
  end

  task automatic reset_dut();
    rst_i = 1'b1;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk_i);
    end
    #5;
    rst_i = 1'b0;
  endtask

  task automatic start_test();
    errors_at_start = error_count;
    ref_run();
    reset_dut();
  endtask

  task automatic finish_test(input int num, input string name, input bit idle_window);
    int n;
    int errs;
    n = 0;
    while (!halt_o && n < HALT_TIMEOUT) begin
      @(posedge clk_i);
      #5;
      n++;
    end
    if (!halt_o) begin
      $display("halt_o did not rise within %0d cycles", HALT_TIMEOUT);
      error_count++;
    end else if (idle_window) begin
      for (int i = 0; i < 20; i++) begin
        @(posedge clk_i);
        #5;
        check_bit("cyc_o", cyc_o, 1'b0);
        check_bit("halt_o", halt_o, 1'b1);
      end
    end
    if (exp_addr_q.size() != 0) begin
      $display("%0d expected stores never reached the bus", exp_addr_q.size());
      error_count++;
      exp_addr_q.delete();
      exp_data_q.delete();
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_word($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    end
    errs = error_count - errors_at_start;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %0d, %s: %s, %0d errors", num, name, (errs == 0) ? "passed" : "failed", errs);
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;

    new_program();
    emit(enc_ldi(1, 32'h55));
    emit(enc_mem(`OP_ST, 1, 0, 32'h200));
    emit({`OP_HALT, 24'h0});
    errors_at_start = error_count;
    ref_run();
    rst_i = 1'b1;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk_i);
    end
    check_bit("cyc_o", cyc_o, 1'b0); // still in reset
    check_bit("we_o", we_o, 1'b0);
    check_bit("halt_o", halt_o, 1'b0);
    #5;
    rst_i = 1'b0;
    @(negedge clk_i); // first cycle after release
    check_bit("cyc_o", cyc_o, 1'b1);
    check_bit("we_o", we_o, 1'b0);
    check_addr("adr_o", adr_o, `CPU_RESET_PC);
    finish_test(1, "reset and first fetch", 1'b0);

    new_program();
    emit(enc_ldi(1, 32'h1234));
    emit(enc_ldi(2, -5));
    emit(enc_ldi(3, 3));
    emit(enc_ldi(5, 32'h200));
    for (int k = 0; k < 7; k++) begin
      emit(enc_alu(4, 1, (k >= 5) ? 3 : 2, k)); // shifts take r3
      emit(enc_mem(`OP_ST, 4, 5, 4 * k));
    end
    emit({`OP_HALT, 24'h0});
    start_test();
    finish_test(2, "alu functions", 1'b0);

    new_program();
    emit(enc_ldi(5, 32'h240));
    emit(enc_mem(`OP_LD, 1, 5, -16));
    emit(enc_mem(`OP_LD, 2, 5, 8));
    emit(enc_alu(3, 1, 2, ALU_XOR));
    emit(enc_mem(`OP_ST, 3, 5, -4));
    emit(enc_mem(`OP_ST, 1, 5, 12));
    emit(enc_mem(`OP_LD, 4, 5, -4)); // reads back the store
    emit(enc_alu(6, 4, 2, ALU_ADD));
    emit(enc_mem(`OP_ST, 6, 5, 0));
    emit(enc_mem(`OP_ST, 2, 5, -32));
    emit({`OP_HALT, 24'h0});
    start_test();
    finish_test(3, "loads and stores", 1'b0);

    new_program();
    emit(enc_ldi(1, 7));
    emit(enc_ldi(2, 7));
    emit(enc_ldi(3, 9));
    emit(enc_ldi(5, 32'h200));
    emit(enc_alu(4, 1, 2, ALU_SUB));
    emit(enc_br(`OP_BEQ, 1)); // taken
    emit(enc_mem(`OP_ST, 1, 5, 0));
    emit(enc_mem(`OP_ST, 3, 5, 4));
    emit(enc_br(`OP_BNE, 1));
    emit(enc_mem(`OP_ST, 1, 5, 8));
    emit(enc_alu(4, 1, 3, ALU_SUB));
    emit(enc_br(`OP_BEQ, 1));
    emit(enc_mem(`OP_ST, 2, 5, 12));
    emit(enc_br(`OP_BNE, 1)); // taken
    emit(enc_mem(`OP_ST, 3, 5, 16));
    emit(enc_ldi(6, 3));
    emit(enc_ldi(7, 1));
    emit(enc_alu(6, 6, 7, ALU_SUB)); // loop counts down to zero
    emit(enc_mem(`OP_ST, 6, 5, 20));
    emit(enc_br(`OP_BNE, -3));
    emit({`OP_HALT, 24'h0});
    start_test();
    finish_test(4, "branches", 1'b0);

    new_program();
    emit(enc_ldi(1, 32'h77));
    emit(enc_mem(`OP_ST, 1, 0, 32'h300));
    emit({`OP_HALT, 24'h0});
    emit(enc_mem(`OP_ST, 1, 0, 32'h304)); // never reached
    start_test();
    finish_test(5, "halt", 1'b1);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== source/cpu_core.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_core
  import cpu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  ack_i,
  input  word_t dat_i,
  output logic  cyc_o,
  output logic  we_o,
  output addr_t adr_o,
  output word_t dat_o,
  output logic  halt_o
);

  // control outputs
  pc_sel_t   pc_sel;
  mar_sel_t  mar_sel;
  mdr_sel_t  mdr_sel;
  reg_sel_t  reg_sel;
  alu2_sel_t alu2_sel;
  addr_sel_t addr_sel;
  logic      ir_write;
  logic      a_write;
  logic      b_write;
  logic      ccr_write;
  logic      reg_write;
  reg_idx_t  rd_addr1;
  reg_idx_t  rd_addr2;
  reg_idx_t  wr_addr;
  alu_func_t alu_func;

  // architectural registers and their next values
  addr_t pc;
  addr_t pc_next;
  word_t ir;
  word_t ir_next;
  addr_t mar;
  addr_t mar_next;
  word_t mdr;
  word_t mdr_next;
  word_t a;
  word_t a_next;
  word_t b;
  word_t b_next;
  ccr_t  ccr;
  ccr_t  ccr_next;

  word_t alu_in2;
  word_t alu_out;
  logic  alu_carry;
  logic  alu_negative;
  logic  alu_overflow;
  logic  alu_zero;
  word_t rd_data1;
  word_t rd_data2;
  word_t reg_wr_data;
  word_t imm_sext;

  assign imm_sext = {{16{ir[`IR_IMM_HI]}}, ir[`IR_IMM_HI:`IR_IMM_LO]};

  assign adr_o = (addr_sel == ADDR_MAR) ? mar : pc;
  assign dat_o = we_o ? mdr : '0;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc  <= `CPU_RESET_PC;
      ir  <= '0;
      mar <= '0;
      mdr <= '0;
      a   <= '0;
      b   <= '0;
      ccr <= '0;
    end else begin
      pc  <= pc_next;
      ir  <= ir_next;
      mar <= mar_next;
      mdr <= mdr_next;
      a   <= a_next;
      b   <= b_next;
      ccr <= ccr_next;
    end
  end

  always_comb begin
    case (pc_sel)
      PC_NEXT: pc_next = pc + 32'd4;
      PC_REL:  pc_next = pc + {imm_sext[29:0], 2'b00}; // pc already past the branch
      default: pc_next = pc;
    endcase
    case (mar_sel)
      MAR_ALU: mar_next = alu_out;
      default: mar_next = mar;
    endcase
    case (mdr_sel)
      MDR_BUS: mdr_next = dat_i;
      MDR_A:   mdr_next = a_next; // store data on its way into a
      default: mdr_next = mdr;
    endcase
    case (reg_sel)
      REG_MDR: reg_wr_data = mdr;
      REG_IMM: reg_wr_data = imm_sext;
      default: reg_wr_data = alu_out;
    endcase
    case (alu2_sel)
      ALU2_IMM: alu_in2 = imm_sext;
      default:  alu_in2 = b;
    endcase
    ir_next  = ir_write ? dat_i : ir;
    a_next   = a_write ? rd_data1 : a;
    b_next   = b_write ? rd_data2 : b;
    ccr_next = ccr_write ? {alu_carry, alu_negative ^ alu_overflow, alu_zero} : ccr;
  end

  cpu_control u_control (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ir_i        (ir),
    .ccr_i       (ccr),
    .ack_i       (ack_i),
    .pc_sel_o    (pc_sel),
    .mar_sel_o   (mar_sel),
    .mdr_sel_o   (mdr_sel),
    .reg_sel_o   (reg_sel),
    .alu2_sel_o  (alu2_sel),
    .addr_sel_o  (addr_sel),
    .ir_write_o  (ir_write),
    .a_write_o   (a_write),
    .b_write_o   (b_write),
    .ccr_write_o (ccr_write),
    .reg_write_o (reg_write),
    .rd_addr1_o  (rd_addr1),
    .rd_addr2_o  (rd_addr2),
    .wr_addr_o   (wr_addr),
    .alu_func_o  (alu_func),
    .cyc_o       (cyc_o),
    .we_o        (we_o),
    .halt_o      (halt_o)
  );

  cpu_alu u_alu (
    .a_i        (a),
    .b_i        (alu_in2),
    .func_i     (alu_func),
    .out_o      (alu_out),
    .carry_o    (alu_carry),
    .negative_o (alu_negative),
    .overflow_o (alu_overflow),
    .zero_o     (alu_zero)
  );

  cpu_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_addr1_i (rd_addr1),
    .rd_addr2_i (rd_addr2),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (reg_wr_data),
    .wr_en_i    (reg_write),
    .rd_data1_o (rd_data1),
    .rd_data2_o (rd_data2)
  );

endmodule

// ==== source/cpu_control.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_control
  import cpu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  word_t     ir_i,
  input  ccr_t      ccr_i,
  input  logic      ack_i,
  output pc_sel_t   pc_sel_o,
  output mar_sel_t  mar_sel_o,
  output mdr_sel_t  mdr_sel_o,
  output reg_sel_t  reg_sel_o,
  output alu2_sel_t alu2_sel_o,
  output addr_sel_t addr_sel_o,
  output logic      ir_write_o,
  output logic      a_write_o,
  output logic      b_write_o,
  output logic      ccr_write_o,
  output logic      reg_write_o,
  output reg_idx_t  rd_addr1_o,
  output reg_idx_t  rd_addr2_o,
  output reg_idx_t  wr_addr_o,
  output alu_func_t alu_func_o,
  output logic      cyc_o,
  output logic      we_o,
  output logic      halt_o
);

  ctrl_state_t state;
  ctrl_state_t next_state;
  opcode_t     opcode;
  reg_idx_t    ra;
  reg_idx_t    rb;
  alu_func_t   ir_func;
  logic        bus_done;
  logic        br_taken;

  assign opcode  = ir_i[`IR_OP_HI:`IR_OP_LO];
  assign ra      = ir_i[`IR_RA_HI:`IR_RA_LO];
  assign rb      = ir_i[`IR_RB_HI:`IR_RB_LO];
  assign ir_func = alu_func_t'(ir_i[`IR_FUNC_HI:`IR_FUNC_LO]);

  assign rd_addr2_o = ir_i[`IR_RC_HI:`IR_RC_LO];
  assign wr_addr_o  = ra;

  // bus strobes come straight from the state
  assign cyc_o    = ~rst_i & ((state == S_FETCH) || (state == S_MEM));
  assign we_o     = ~rst_i & (state == S_MEM) & (opcode == `OP_ST);
  assign bus_done = cyc_o & ack_i; // transfer ends on this edge
  assign br_taken = (opcode == `OP_BEQ) ? ccr_i[`CCR_ZERO] : ~ccr_i[`CCR_ZERO];
  assign halt_o   = (state == S_HALT);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= S_FETCH;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state  = state;
    pc_sel_o    = PC_HOLD;
    mar_sel_o   = MAR_HOLD;
    mdr_sel_o   = MDR_HOLD;
    reg_sel_o   = REG_ALU;
    alu2_sel_o  = ALU2_B;
    addr_sel_o  = ADDR_PC;
    ir_write_o  = 1'b0;
    a_write_o   = 1'b0;
    b_write_o   = 1'b0;
    ccr_write_o = 1'b0;
    reg_write_o = 1'b0;
    rd_addr1_o  = rb;
    alu_func_o  = ALU_ADD;
    case (state)
      S_FETCH: begin
        if (bus_done) begin
          ir_write_o = 1'b1;
          pc_sel_o   = PC_NEXT;
          next_state = S_DECODE;
        end
      end
      S_DECODE: begin
        a_write_o = 1'b1; // rb
        b_write_o = 1'b1; // rc
        case (opcode)
          `OP_LDI, `OP_ALU, `OP_LD, `OP_ST, `OP_BEQ, `OP_BNE: next_state = S_EXEC;
          default: next_state = S_HALT; // halt and anything unknown
        endcase
      end
      S_EXEC: begin
        case (opcode)
          `OP_ALU: begin
            alu_func_o  = ir_func;
            ccr_write_o = 1'b1;
            next_state  = S_WB;
          end
          `OP_LD: begin
            alu2_sel_o = ALU2_IMM;
            mar_sel_o  = MAR_ALU;
            next_state = S_MEM;
          end
          `OP_ST: begin
            alu2_sel_o = ALU2_IMM;
            mar_sel_o  = MAR_ALU;
            rd_addr1_o = ra; // a is free once the address is formed
            a_write_o  = 1'b1;
            mdr_sel_o  = MDR_A;
            next_state = S_MEM;
          end
          `OP_BEQ, `OP_BNE: begin
            if (br_taken) begin
              pc_sel_o = PC_REL;
            end
            next_state = S_FETCH;
          end
          `OP_LDI: next_state = S_WB;
          default: next_state = S_HALT;
        endcase
      end
      S_MEM: begin
        addr_sel_o = ADDR_MAR;
        if (bus_done) begin
          if (opcode == `OP_LD) begin
            mdr_sel_o  = MDR_BUS;
            next_state = S_WB;
          end else begin
            next_state = S_FETCH;
          end
        end
      end
      S_WB: begin
        reg_write_o = 1'b1;
        alu_func_o  = ir_func; // a and b still hold the operands
        case (opcode)
          `OP_LDI: reg_sel_o = REG_IMM;
          `OP_LD:  reg_sel_o = REG_MDR;
          default: reg_sel_o = REG_ALU;
        endcase
        next_state = S_FETCH;
      end
      S_HALT: next_state = S_HALT;
      default: next_state = S_HALT;
    endcase
  end

endmodule

// ==== source/cpu_regfile.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_regfile
  import cpu_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_idx_t rd_addr1_i,
  input  reg_idx_t rd_addr2_i,
  input  reg_idx_t wr_addr_i,
  input  word_t    wr_data_i,
  input  logic     wr_en_i,
  output word_t    rd_data1_o,
  output word_t    rd_data2_o
);

  word_t regs [`CPU_NUM_REGS];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // reads are combinational
  assign rd_data1_o = regs[rd_addr1_i];
  assign rd_data2_o = regs[rd_addr2_i];

endmodule

// ==== source/cpu_alu.sv ====
`timescale 1ns/1ns

module cpu_alu
  import cpu_pkg::*;
(
  input  word_t     a_i,
  input  word_t     b_i,
  input  alu_func_t func_i,
  output word_t     out_o,
  output logic      carry_o,
  output logic      negative_o,
  output logic      overflow_o,
  output logic      zero_o
);

  logic [32:0] sum;
  logic [4:0]  shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    sum        = '0;
    out_o      = '0;
    carry_o    = 1'b0;
    overflow_o = 1'b0;
    case (func_i)
      ALU_ADD: begin
        sum        = {1'b0, a_i} + {1'b0, b_i};
        out_o      = sum[31:0];
        carry_o    = sum[32];
        overflow_o = (a_i[31] == b_i[31]) && (out_o[31] != a_i[31]);
      end
      ALU_SUB: begin
        sum        = {1'b0, a_i} - {1'b0, b_i};
        out_o      = sum[31:0];
        carry_o    = sum[32]; // borrow
        overflow_o = (a_i[31] != b_i[31]) && (out_o[31] != a_i[31]);
      end
      ALU_AND: out_o = a_i & b_i;
      ALU_OR:  out_o = a_i | b_i;
      ALU_XOR: out_o = a_i ^ b_i;
      ALU_SHL: out_o = a_i << shamt;
      ALU_SHR: out_o = a_i >> shamt; // logical
      default: out_o = '0;
    endcase
  end

  assign negative_o = out_o[31];
  assign zero_o     = (out_o == '0);

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t; // byte address
  typedef logic [3:0]  reg_idx_t;
  typedef logic [7:0]  opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SHL = 3'd5,
    ALU_SHR = 3'd6
  } alu_func_t;

  // carry, less-than, zero
  typedef logic [2:0] ccr_t;

  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXEC,
    S_MEM,
    S_WB,
    S_HALT
  } ctrl_state_t;

  // datapath mux selects
  typedef enum logic [1:0] {PC_HOLD, PC_NEXT, PC_REL} pc_sel_t;

  typedef enum logic {MAR_HOLD, MAR_ALU} mar_sel_t;

  typedef enum logic [1:0] {MDR_HOLD, MDR_BUS, MDR_A} mdr_sel_t;

  typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_IMM} reg_sel_t;

  typedef enum logic {ALU2_B, ALU2_IMM} alu2_sel_t;

  typedef enum logic {ADDR_PC, ADDR_MAR} addr_sel_t;

endpackage

// ==== source/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// first fetch address
`define CPU_RESET_PC 32'h0000_0000

`define CPU_NUM_REGS 16

// instruction fields
`define IR_OP_HI   31
`define IR_OP_LO   24
`define IR_RA_HI   23 // dest, or store source
`define IR_RA_LO   20
`define IR_RB_HI   19
`define IR_RB_LO   16
`define IR_RC_HI   15
`define IR_RC_LO   12
`define IR_FUNC_HI 2
`define IR_FUNC_LO 0
`define IR_IMM_HI  15 // signed immediate
`define IR_IMM_LO  0

// opcodes
`define OP_LDI  8'h01
`define OP_ALU  8'h02
`define OP_LD   8'h03
`define OP_ST   8'h04
`define OP_BEQ  8'h05
`define OP_BNE  8'h06
`define OP_HALT 8'hff

// condition code bits
`define CCR_CARRY 2
`define CCR_LT    1
`define CCR_ZERO  0

`endif
